// File: rtl/i2c_cfg.svh
// --------------------
// i2c master constants: device address,
// phase timing and data word width
// --------------------

`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// address byte sent after START, write bit included
`define I2C_DEVICE_ADDR 8'h34

// phase timer reload, clk rate / (3 * bit rate)
`define I2C_TIMING_CONST 50

`define I2C_WORD_BITS 16 // one transfer = high byte + low byte

`endif

// File: rtl/i2c_pkg.sv
// --------------------
// i2c master types: engine function codes,
// byte command and transfer response
// --------------------

`default_nettype none

package i2c_pkg;

  // byte engine functions
  typedef enum logic [1:0] {
    BYTE_START = 2'b00,
    BYTE_STOP  = 2'b01,
    BYTE_SEND  = 2'b10
  } byte_fnc_t;

  // bit engine functions
  // msb set means a data bit, lsb is the bit value
  typedef enum logic [1:0] {
    BIT_START  = 2'b00,
    BIT_STOP   = 2'b01,
    BIT_SEND_0 = 2'b10,
    BIT_SEND_1 = 2'b11  // sda released, so also reads ack
  } bit_fnc_t;

  typedef struct packed {
    byte_fnc_t  fnc;
    logic [7:0] data;
  } byte_cmd_t;

  // error is the received bit when coming from the bit engine
  typedef struct packed {
    logic done;
    logic error;
  } xfer_rsp_t;

endpackage

`default_nettype wire

// File: rtl/i2c_phy.sv
// --------------------
// open-drain scl/sda drivers, sda input sync
// --------------------

`timescale 1ns/10ps
`default_nettype none

module i2c_phy (
  input  wire  clk,
  input  wire  rst,
  input  wire  scl_rel,
  input  wire  sda_rel,
  output logic sda_in,
  inout  wire  i2c_scl,
  inout  wire  i2c_sda
);

  logic sda_meta;

  // pull low or float, pull-ups do the rest
  assign i2c_scl = scl_rel ? 1'bz : 1'b0;
  assign i2c_sda = sda_rel ? 1'bz : 1'b0;

  always_ff @(posedge clk) begin
    if (rst) begin
      sda_meta <= 1'b1; // idle bus reads high
      sda_in   <= 1'b1;
    end else begin
      sda_meta <= i2c_sda;
      sda_in   <= sda_meta;
    end
  end

endmodule

`default_nettype wire

// File: rtl/i2c_bit.sv
// --------------------
// i2c bit engine: three-phase START, STOP
// and data symbols, ack bit sampling
// --------------------

`timescale 1ns/10ps
`default_nettype none
`include "i2c_cfg.svh"

module i2c_bit #(
  parameter int PHASE_CYCLES = `I2C_TIMING_CONST
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire i2c_pkg::bit_fnc_t fnc,
  input  wire                   start,
  output i2c_pkg::xfer_rsp_t    rsp,
  inout  wire                   i2c_scl,
  inout  wire                   i2c_sda
);

  localparam int TIMER_W = $clog2(PHASE_CYCLES + 1);

  // phases of one symbol are numbered consecutively
  typedef enum logic [3:0] {
    ST_IDLE    = 4'd0,
    ST_START_A = 4'd1,
    ST_START_B = 4'd2,
    ST_START_C = 4'd3,
    ST_STOP_A  = 4'd4,
    ST_STOP_B  = 4'd5,
    ST_STOP_C  = 4'd6,
    ST_SEND_A  = 4'd7,
    ST_SEND_B  = 4'd8,
    ST_SEND_C  = 4'd9
  } state_t;

  state_t             state;
  state_t             state_nxt;
  logic [TIMER_W-1:0] timer;
  logic               timer_load;
  logic               timer_done;
  logic               bit_done;
  logic               bit_rcv;
  logic               scl_rel;
  logic               sda_rel;
  logic               sda_in;

  // -------------------
  // phase timer
  // -------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      timer <= '0;
    end else if (timer_load) begin
      timer <= TIMER_W'(PHASE_CYCLES);
    end else if (!timer_done) begin
      timer <= timer - 1'b1;
    end
  end

  assign timer_done = (timer == '0);

  // -------------------
  // symbol FSM
  // -------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt  = state;
    timer_load = 1'b0;
    bit_done   = 1'b0;
    case (state)
      ST_IDLE: begin
        if (start) begin
          timer_load = 1'b1;
          case (fnc)
            i2c_pkg::BIT_START: state_nxt = ST_START_A;
            i2c_pkg::BIT_STOP:  state_nxt = ST_STOP_A;
            default:            state_nxt = ST_SEND_A;
          endcase
        end
      end
      ST_START_A, ST_START_B, ST_STOP_A, ST_STOP_B, ST_SEND_A, ST_SEND_B: begin
        if (timer_done) begin
          timer_load = 1'b1;
          state_nxt  = state_t'(state + 4'd1); // next phase
        end
      end
      ST_START_C, ST_STOP_C, ST_SEND_C: begin
        if (timer_done) begin
          state_nxt = ST_IDLE;
          bit_done  = 1'b1;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  // release levels, one register stage behind the phase
  always_ff @(posedge clk) begin
    if (rst) begin
      scl_rel <= 1'b1;
      sda_rel <= 1'b1;
    end else begin
      case (state)
        ST_START_A, ST_STOP_C: begin
          scl_rel <= 1'b1;
          sda_rel <= 1'b1;
        end
        ST_START_B, ST_STOP_B: begin
          scl_rel <= 1'b1;
          sda_rel <= 1'b0;
        end
        ST_START_C, ST_STOP_A: begin
          scl_rel <= 1'b0;
          sda_rel <= 1'b0;
        end
        ST_SEND_A, ST_SEND_C: begin
          scl_rel <= 1'b0;
          sda_rel <= fnc[0];
        end
        ST_SEND_B: begin
          scl_rel <= 1'b1;
          sda_rel <= fnc[0];
        end
        default: ;
      endcase
    end
  end

  // sample sda near the middle of scl high
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_rcv <= 1'b0;
    end else if (state == ST_SEND_B && timer == TIMER_W'(PHASE_CYCLES / 2 - 2)) begin
      bit_rcv <= sda_in;
    end
  end

  assign rsp = '{done: bit_done, error: bit_rcv};

  i2c_phy u_phy (
    .clk     (clk),
    .rst     (rst),
    .scl_rel (scl_rel),
    .sda_rel (sda_rel),
    .sda_in  (sda_in),
    .i2c_scl (i2c_scl),
    .i2c_sda (i2c_sda)
  );

endmodule

`default_nettype wire

// File: rtl/i2c_byte.sv
// --------------------
// i2c byte engine: START, STOP and byte send
// with ack check
// --------------------

`timescale 1ns/10ps
`default_nettype none

module i2c_byte (
  input  wire                    clk,
  input  wire                    rst,
  input  wire i2c_pkg::byte_cmd_t cmd,
  input  wire                    start,
  output i2c_pkg::xfer_rsp_t     rsp,
  inout  wire                    i2c_scl,
  inout  wire                    i2c_sda
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_STOP,
    ST_SEND_1,  // setup cycle before a data bit
    ST_SEND_2,
    ST_ACK_1,
    ST_ACK_2
  } state_t;

  state_t             state;
  state_t             state_nxt;
  logic [2:0]         bit_cnt;
  logic               cnt_load;
  logic               cnt_step;
  logic               cnt_done;
  i2c_pkg::bit_fnc_t  bit_fnc;
  logic               bit_start;
  i2c_pkg::xfer_rsp_t bit_rsp;
  logic               byte_done;
  logic               byte_error;

  // msb first, stops at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt <= 3'd0;
    end else if (cnt_load) begin
      bit_cnt <= 3'd7;
    end else if (cnt_step && !cnt_done) begin
      bit_cnt <= bit_cnt - 3'd1;
    end
  end

  assign cnt_done = (bit_cnt == 3'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt  = state;
    cnt_load   = 1'b0;
    cnt_step   = 1'b0;
    bit_start  = 1'b0;
    byte_done  = 1'b0;
    byte_error = 1'b0;
    case (state)
      ST_IDLE: begin
        if (start) begin
          case (cmd.fnc)
            i2c_pkg::BYTE_START: begin
              state_nxt = ST_START;
              bit_start = 1'b1;
            end
            i2c_pkg::BYTE_STOP: begin
              state_nxt = ST_STOP;
              bit_start = 1'b1;
            end
            i2c_pkg::BYTE_SEND: begin
              state_nxt = ST_SEND_1;
              cnt_load  = 1'b1;
            end
            default: ;
          endcase
        end
      end
      ST_START, ST_STOP: begin
        if (bit_rsp.done) begin
          state_nxt = ST_IDLE;
          byte_done = 1'b1;
        end
      end
      ST_SEND_1: begin
        state_nxt = ST_SEND_2;
        bit_start = 1'b1;
      end
      ST_SEND_2: begin
        if (bit_rsp.done) begin
          state_nxt = cnt_done ? ST_ACK_1 : ST_SEND_1;
          cnt_step  = 1'b1;
        end
      end
      ST_ACK_1: begin
        state_nxt = ST_ACK_2;
        bit_start = 1'b1;
      end
      ST_ACK_2: begin
        if (bit_rsp.done) begin
          state_nxt  = ST_IDLE;
          byte_done  = 1'b1;
          byte_error = bit_rsp.error; // sda high means no ack
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_comb begin
    case (state)
      ST_IDLE: begin
        if (cmd.fnc == i2c_pkg::BYTE_STOP) begin
          bit_fnc = i2c_pkg::BIT_STOP;
        end else begin
          bit_fnc = i2c_pkg::BIT_START;
        end
      end
      ST_START: bit_fnc = i2c_pkg::BIT_START;
      ST_STOP:  bit_fnc = i2c_pkg::BIT_STOP;
      ST_ACK_1, ST_ACK_2: bit_fnc = i2c_pkg::BIT_SEND_1;
      default:  bit_fnc = i2c_pkg::bit_fnc_t'({1'b1, cmd.data[bit_cnt]});
    endcase
  end

  assign rsp = '{done: byte_done, error: byte_error};

  i2c_bit u_bit (
    .clk     (clk),
    .rst     (rst),
    .fnc     (bit_fnc),
    .start   (bit_start),
    .rsp     (bit_rsp),
    .i2c_scl (i2c_scl),
    .i2c_sda (i2c_sda)
  );

endmodule

`default_nettype wire

// File: rtl/i2c_master.sv
// --------------------
// i2c master top: write of one data word to
// a fixed device, done/error reporting
// --------------------

`timescale 1ns/10ps
`default_nettype none
`include "i2c_cfg.svh"

module i2c_master (
  input  wire                      clk,
  input  wire                      rst,
  input  wire [`I2C_WORD_BITS-1:0] data,
  input  wire                      start,
  output logic                     done,
  output logic                     error,
  inout  wire                      i2c_scl,
  inout  wire                      i2c_sda
);

  // *_1 issues the byte command, *_2 waits for its done
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_START_1,
    ST_START_2,
    ST_ADDR_1,
    ST_ADDR_2,
    ST_HI_1,
    ST_HI_2,
    ST_LO_1,
    ST_LO_2,
    ST_SUCC_1,
    ST_SUCC_2,
    ST_FAIL_1,
    ST_FAIL_2
  } state_t;

  state_t              state;
  state_t              state_nxt;
  i2c_pkg::byte_cmd_t  byte_cmd;
  logic                byte_start;
  i2c_pkg::xfer_rsp_t  byte_rsp;

  // -------------------
  // sequencer
  // -------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:    if (start) state_nxt = ST_START_1;
      ST_START_1: state_nxt = ST_START_2;
      ST_START_2: if (byte_rsp.done) state_nxt = ST_ADDR_1;
      ST_ADDR_1:  state_nxt = ST_ADDR_2;
      ST_ADDR_2: begin
        if (byte_rsp.done) begin
          state_nxt = byte_rsp.error ? ST_FAIL_1 : ST_HI_1;
        end
      end
      ST_HI_1:    state_nxt = ST_HI_2;
      ST_HI_2: begin
        if (byte_rsp.done) begin
          state_nxt = byte_rsp.error ? ST_FAIL_1 : ST_LO_1;
        end
      end
      ST_LO_1:    state_nxt = ST_LO_2;
      ST_LO_2: begin
        if (byte_rsp.done) begin
          state_nxt = byte_rsp.error ? ST_FAIL_1 : ST_SUCC_1;
        end
      end
      ST_SUCC_1:  state_nxt = ST_SUCC_2;
      ST_FAIL_1:  state_nxt = ST_FAIL_2;
      ST_SUCC_2, ST_FAIL_2: if (byte_rsp.done) state_nxt = ST_IDLE;
      default:    state_nxt = ST_IDLE;
    endcase
  end

  // command held over both states of a step
  always_comb begin
    byte_cmd.fnc  = i2c_pkg::BYTE_SEND;
    byte_cmd.data = 8'h00;
    case (state)
      ST_START_1, ST_START_2: byte_cmd.fnc = i2c_pkg::BYTE_START;
      ST_ADDR_1, ST_ADDR_2:   byte_cmd.data = `I2C_DEVICE_ADDR;
      ST_HI_1, ST_HI_2:       byte_cmd.data = data[`I2C_WORD_BITS-1 -: 8];
      ST_LO_1, ST_LO_2:       byte_cmd.data = data[7:0];
      default:                byte_cmd.fnc = i2c_pkg::BYTE_STOP; // idle and both STOPs
    endcase
  end

  assign byte_start = state inside {ST_START_1, ST_ADDR_1, ST_HI_1, ST_LO_1,
                                    ST_SUCC_1, ST_FAIL_1};

  // status follows the final STOP done
  assign done  = byte_rsp.done && (state == ST_SUCC_2 || state == ST_FAIL_2);
  assign error = byte_rsp.done && (state == ST_FAIL_2);

  i2c_byte u_byte (
    .clk     (clk),
    .rst     (rst),
    .cmd     (byte_cmd),
    .start   (byte_start),
    .rsp     (byte_rsp),
    .i2c_scl (i2c_scl),
    .i2c_sda (i2c_sda)
  );

endmodule

`default_nettype wire

// File: tests/i2c_slave_model.sv
// --------------------
// behavioral i2c slave: START/STOP/byte decode,
// ack or withheld ack per byte index
// --------------------

`timescale 1ns/10ps
`default_nettype none

module i2c_slave_model (
  input  wire        clk,
  input  wire        clear,
  input  int         nack_idx,  // byte without ack, -1 for none
  output int         start_cnt,
  output int         stop_cnt,
  output int         byte_cnt,
  output logic [7:0] rx_bytes [0:7],
  inout  wire        i2c_scl,
  inout  wire        i2c_sda
);

  logic       scl_q;
  logic       sda_q;
  logic [7:0] shift;
  int         bit_cnt;
  logic       ack_pend;
  logic       ack_phase;
  logic       sda_low;

  assign i2c_sda = sda_low ? 1'b0 : 1'bz;

  // bus sampled on clk, edges found against last sample
  always @(posedge clk) begin
    scl_q <= i2c_scl;
    sda_q <= i2c_sda;
    if (clear) begin
      start_cnt <= 0;
      stop_cnt  <= 0;
      byte_cnt  <= 0;
      bit_cnt   <= 0;
      ack_pend  <= 1'b0;
      ack_phase <= 1'b0;
      sda_low   <= 1'b0;
    end else if (i2c_scl && scl_q && sda_q && !i2c_sda) begin
      start_cnt <= start_cnt + 1; // START
      bit_cnt   <= 0;
    end else if (i2c_scl && scl_q && !sda_q && i2c_sda) begin
      stop_cnt  <= stop_cnt + 1;  // STOP
      ack_pend  <= 1'b0;
      ack_phase <= 1'b0;
      sda_low   <= 1'b0;
    end else if (!scl_q && i2c_scl && !ack_phase) begin
      shift <= {shift[6:0], i2c_sda};
      if (bit_cnt == 7) begin
        bit_cnt  <= 0;
        ack_pend <= 1'b1;
        if (byte_cnt < 8) rx_bytes[byte_cnt] <= {shift[6:0], i2c_sda};
        byte_cnt <= byte_cnt + 1;
      end else begin
        bit_cnt <= bit_cnt + 1;
      end
    end else if (scl_q && !i2c_scl) begin
      if (ack_pend) begin
        ack_pend  <= 1'b0;
        ack_phase <= 1'b1;
        sda_low   <= (byte_cnt - 1 != nack_idx); // drive ack low
      end else if (ack_phase) begin
        ack_phase <= 1'b0;
        sda_low   <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/i2c_master_properties.sv
// --------------------
// status output rules of the i2c master
// --------------------

`timescale 1ns/10ps
`default_nettype none

module i2c_master_properties (
  input wire clk,
  input wire rst,
  input wire start,
  input wire done,
  input wire error
);

  logic start_seen; // start since last done

  always_ff @(posedge clk) begin
    if (rst) begin
      start_seen <= 1'b0;
    end else if (start) begin
      start_seen <= 1'b1;
    end else if (done) begin
      start_seen <= 1'b0;
    end
  end

  a_error_with_done: assert property (@(posedge clk) disable iff (rst) error |-> done)
    else $error("error high without done");

  a_done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("done high for two cycles");

  a_done_after_start: assert property (@(posedge clk) disable iff (rst) done |-> start_seen)
    else $error("done without a new start");

endmodule

bind i2c_master i2c_master_properties u_props (
  .clk   (clk),
  .rst   (rst),
  .start (start),
  .done  (done),
  .error (error)
);

`default_nettype wire

// File: tests/tb_i2c_master.sv
// --------------------
// i2c master testbench: DUT, pull-ups,
// slave model and directed tests
// --------------------

`timescale 1ns/10ps
`default_nettype none
`include "i2c_cfg.svh"

module tb_i2c_master;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int QUIET_CYCLES   = 8000; // longer than one whole transfer

  logic                      clk;
  logic                      rst;
  logic [`I2C_WORD_BITS-1:0] data;
  logic                      start;
  logic                      done;
  logic                      error;
  wire                       i2c_scl;
  wire                       i2c_sda;
  logic                      clear;
  int                        nack_idx;
  int                        start_cnt;
  int                        stop_cnt;
  int                        byte_cnt;
  logic [7:0]                rx_bytes [0:7];
  int                        done_cnt = 0;
  int                        seed;

  pullup (i2c_scl);
  pullup (i2c_sda);

  i2c_master u_dut (
    .clk     (clk),
    .rst     (rst),
    .data    (data),
    .start   (start),
    .done    (done),
    .error   (error),
    .i2c_scl (i2c_scl),
    .i2c_sda (i2c_sda)
  );

  i2c_slave_model u_slave (
    .clk       (clk),
    .clear     (clear),
    .nack_idx  (nack_idx),
    .start_cnt (start_cnt),
    .stop_cnt  (stop_cnt),
    .byte_cnt  (byte_cnt),
    .rx_bytes  (rx_bytes),
    .i2c_scl   (i2c_scl),
    .i2c_sda   (i2c_sda)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(negedge clk) begin
    if (!rst && done) done_cnt <= done_cnt + 1;
  end

  // --------------------
  // helpers
  // --------------------
  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic pulse_start(input logic [`I2C_WORD_BITS-1:0] word);
    @(posedge clk);
    #2;
    data  = word;
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  task automatic prepare_slave(input int nack);
    @(posedge clk);
    #2;
    nack_idx = nack;
    clear    = 1'b1;
    @(posedge clk);
    #2;
    clear = 1'b0;
  endtask

  task automatic wait_for_done(input string name, output logic err);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    err    = 1'b0;
    while (!seen) begin
      @(negedge clk);
      if (done) begin
        seen = 1'b1;
        err  = error;
      end else begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
          $display("timeout in %s: the DUT never raised done", name);
          $display("TESTS FAILED");
          $fatal(1, "timeout");
        end
      end
    end
  endtask

  // one START, one STOP, address then the word's bytes
  task automatic check_bus(input string name, input logic [`I2C_WORD_BITS-1:0] word,
                           input int nbytes);
    logic [7:0] exp_bytes [0:2];
    exp_bytes[0] = `I2C_DEVICE_ADDR;
    exp_bytes[1] = word[15:8];
    exp_bytes[2] = word[7:0];
    compare({name, " start count"}, 1, start_cnt);
    compare({name, " stop count"}, 1, stop_cnt);
    compare({name, " byte count"}, nbytes, byte_cnt);
    for (int i = 0; i < nbytes; i++) begin
      compare($sformatf("%s byte %0d", name, i), exp_bytes[i], rx_bytes[i]);
    end
  endtask

  task automatic write_and_check(input string name, input logic [`I2C_WORD_BITS-1:0] word,
                                 input int nack, input logic exp_err, input int nbytes);
    logic err;
    prepare_slave(nack);
    pulse_start(word);
    wait_for_done(name, err);
    compare({name, " error"}, exp_err, err);
    check_bus(name, word, nbytes);
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic reset_state();
    @(negedge clk);
    compare("reset done", 0, done);
    compare("reset error", 0, error);
    compare("reset scl", 1, i2c_scl);
    compare("reset sda", 1, i2c_sda);
  endtask

  task automatic random_back_to_back();
    logic [31:0] rnd;
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      write_and_check($sformatf("random word %0d", i), rnd[15:0], -1, 1'b0, 3);
    end
  endtask

  task automatic start_while_busy();
    int   done_before;
    logic err;
    prepare_slave(-1);
    done_before = done_cnt;
    pulse_start(16'h1234);
    repeat (300) @(posedge clk);
    pulse_start(16'h1234); // lands mid-transfer
    wait_for_done("start while busy", err);
    compare("start while busy error", 0, err);
    repeat (QUIET_CYCLES) @(posedge clk);
    compare("start while busy done count", 1, done_cnt - done_before);
    check_bus("start while busy", 16'h1234, 3);
  endtask

  initial begin
    rst      = 1'b1;
    start    = 1'b0;
    data     = '0;
    clear    = 1'b1;
    nack_idx = -1;
    seed     = 32'h3a23_0b00;
    repeat (5) @(posedge clk);
    #2;
    rst   = 1'b0;
    clear = 1'b0;

    reset_state();
    write_and_check("write acked", 16'hA55A, -1, 1'b0, 3);
    write_and_check("nack on address", 16'hA55A, 0, 1'b1, 1);
    write_and_check("nack on high byte", 16'hC3E1, 1, 1'b1, 2);
    random_back_to_back();
    start_while_busy();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+rtl
rtl/i2c_pkg.sv
rtl/i2c_phy.sv
rtl/i2c_bit.sv
rtl/i2c_byte.sv
rtl/i2c_master.sv
tests/i2c_slave_model.sv
tests/i2c_master_properties.sv
tests/tb_i2c_master.sv

// File: Makefile
# Verilator build and run for the i2c master testbench

SIM  := obj_dir/Vtb_i2c_master
SRCS := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

.PHONY: all run clean

all: run

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_i2c_master -o Vtb_i2c_master

# pass only if the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
